// ==== src/tlbPkg.sv ====
/*
  Shared SV32 field widths, TLB sizing and the enum types used across the
  data TLB. Modules import this package inside their bodies and use scoped
  names for port declarations.
*/

package tlbPkg;

  //////////////////////////////////////////////////////////////////////////
  // Sizing
  //////////////////////////////////////////////////////////////////////////

  // The TLB holds 2**ENTRY_BITS entries
  localparam int ENTRY_BITS  = 3;
  localparam int NUM_ENTRIES = 1 << ENTRY_BITS;

  //////////////////////////////////////////////////////////////////////////
  // SV32 address fields
  //////////////////////////////////////////////////////////////////////////

  // Virtual address is VPN1 (10) : VPN0 (10) : offset (12)
  localparam int VA_BITS      = 32;
  localparam int VPN_BITS     = 20;
  localparam int VPN_SEG_BITS = 10;
  localparam int OFFSET_BITS  = 12;

  // Physical address is PPN1 (12) : PPN0 (10) : offset (12)
  localparam int PA_BITS  = 34;
  localparam int PPN_BITS = 22;

  // Low byte of a PTE holds D A G U X W R V
  localparam int PERM_BITS = 8;

  //////////////////////////////////////////////////////////////////////////
  // Enumerations
  //////////////////////////////////////////////////////////////////////////

  // Current privilege of the hart, encoded as in the mstatus MPP field
  typedef enum logic [1:0] {
    privUser    = 2'b00,
    privSuper   = 2'b01,
    privMachine = 2'b11
  } privMode_t;

  // Bit 1 flags a read and bit 0 flags a write, both set for an AMO
  typedef enum logic [1:0] {
    accNone      = 2'b00,
    accWrite     = 2'b01,
    accRead      = 2'b10,
    accReadWrite = 2'b11
  } accessType_t;

  // A megapage covers 4 MiB and ignores VPN0 when matching
  typedef enum logic {
    pageKilo = 1'b0,
    pageMega = 1'b1
  } pageType_t;

endpackage

// ==== src/tlbCam.sv ====
/*
  Tag store of the data TLB. Holds the virtual page number, page type and
  valid bit of every entry and compares all of them against the lookup VPN
  in the same cycle, reporting the lowest matching slot.
*/

`timescale 1ns/1ps

module tlbCam (
  input  logic                            clk,
  input  logic                            rstN,
  input  logic [tlbPkg::VPN_BITS-1:0]     vpn,
  input  logic                            tlbWrite,
  input  logic                            tlbFlush,
  input  logic [tlbPkg::ENTRY_BITS-1:0]   writeIndex,
  input  tlbPkg::pageType_t               pageTypeWrite,
  output logic                            camHit,
  output logic [tlbPkg::ENTRY_BITS-1:0]   hitIndex,
  output tlbPkg::pageType_t               hitPageType,
  output logic [tlbPkg::NUM_ENTRIES-1:0]  validVec
);

  import tlbPkg::*;

  // Stored tags, one per entry
  logic [VPN_BITS-1:0] vpnStore  [NUM_ENTRIES];
  pageType_t           typeStore [NUM_ENTRIES];

  // Per-entry compare results
  logic [NUM_ENTRIES-1:0] segOneMatch;
  logic [NUM_ENTRIES-1:0] segZeroMatch;
  logic [NUM_ENTRIES-1:0] matchVec;

  ////////////////////////////////////////////////////////////////////////////
  // Tag and valid storage
  ////////////////////////////////////////////////////////////////////////////

  // Tag fields are written together with the slot picked by the LRU
  always_ff @(posedge clk) begin
    if (tlbWrite) begin
      vpnStore[writeIndex]  <= vpn;
      typeStore[writeIndex] <= pageTypeWrite;
    end
  end

  // A flush on the same edge as a write wins, so the new entry is dropped
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      validVec <= '0;
    end else if (tlbFlush) begin
      validVec <= '0;
    end else if (tlbWrite) begin
      validVec[writeIndex] <= 1'b1;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Parallel compare
  ////////////////////////////////////////////////////////////////////////////

  for (genvar i = 0; i < NUM_ENTRIES; i++) begin : gMatch
    // VPN1 always has to agree
    assign segOneMatch[i] =
      (vpnStore[i][VPN_BITS-1 -: VPN_SEG_BITS] == vpn[VPN_BITS-1 -: VPN_SEG_BITS]);
    // VPN0 is an offset into a megapage and only counts for kilopages
    assign segZeroMatch[i] = (typeStore[i] == pageMega) ||
      (vpnStore[i][VPN_SEG_BITS-1:0] == vpn[VPN_SEG_BITS-1:0]);
    assign matchVec[i] = validVec[i] && segOneMatch[i] && segZeroMatch[i];
  end

  // Walk from the top down so the lowest matching slot is the one kept
  always_comb begin
    hitIndex = '0;
    for (int i = NUM_ENTRIES - 1; i >= 0; i--) begin
      if (matchVec[i]) begin
        hitIndex = ENTRY_BITS'(i);
      end
    end
  end

  assign camHit      = |matchVec;
  assign hitPageType = typeStore[hitIndex];

endmodule

// ==== src/tlbRam.sv ====
/*
  Data side of the TLB entries. Keeps the physical page number and the PTE
  flag byte of each slot, written from a raw SV32 PTE and read without a
  clock at the index reported by the tag store.
*/

`timescale 1ns/1ps

module tlbRam (
  input  logic                           clk,
  input  logic                           tlbWrite,
  input  logic [tlbPkg::ENTRY_BITS-1:0]  writeIndex,
  input  logic [31:0]                    pteWrite,
  input  logic [tlbPkg::ENTRY_BITS-1:0]  hitIndex,
  output logic [tlbPkg::PPN_BITS-1:0]    ppn,
  output logic [tlbPkg::PERM_BITS-1:0]   perm
);

  import tlbPkg::*;

  // SV32 PTE layout
  //   [31:20] PPN1, [19:10] PPN0, [9:8] RSW, [7:0] D A G U X W R V
  logic [PPN_BITS-1:0]  ppnStore  [NUM_ENTRIES];
  logic [PERM_BITS-1:0] permStore [NUM_ENTRIES];

  // Fields pulled out of the incoming PTE
  logic [PPN_BITS-1:0]  ptePpn;
  logic [PERM_BITS-1:0] ptePerm;

  // The RSW bits belong to software and are not kept
  assign ptePpn  = pteWrite[31 -: PPN_BITS];
  assign ptePerm = pteWrite[PERM_BITS-1:0];

  ////////////////////////////////////////////////////////////////////////////
  // Write port
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (tlbWrite) begin
      ppnStore[writeIndex]  <= ptePpn;
      permStore[writeIndex] <= ptePerm;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Read port
  ////////////////////////////////////////////////////////////////////////////

  // Contents of a slot that did not hit are don't-care, the top level masks
  // them with the hit signal
  assign ppn  = ppnStore[hitIndex];
  assign perm = permStore[hitIndex];

endmodule

// ==== src/tlbLru.sv ====
/*
  Replacement unit of the TLB. Keeps a binary tree pseudo-LRU over all
  entries, offers the lowest empty slot first and the tree victim once
  every slot is valid.
*/

`timescale 1ns/1ps

module tlbLru (
  input  logic                            clk,
  input  logic                            rstN,
  input  logic                            tlbHit,
  input  logic [tlbPkg::ENTRY_BITS-1:0]   hitIndex,
  input  logic                            tlbWrite,
  input  logic [tlbPkg::NUM_ENTRIES-1:0]  validVec,
  output logic [tlbPkg::ENTRY_BITS-1:0]   writeIndex
);

  import tlbPkg::*;

  // Node n has children 2n+1 and 2n+2, a set bit sends the victim right
  logic [NUM_ENTRIES-2:0] tree;
  logic [NUM_ENTRIES-2:0] treeNext;
  logic [ENTRY_BITS-1:0]  treeVictim;
  logic [ENTRY_BITS-1:0]  freeIndex;
  logic                   anyFree;

  // Steer every node on the path of idx toward the other half
  function automatic logic [NUM_ENTRIES-2:0] touchTree(
    input logic [NUM_ENTRIES-2:0] treeIn,
    input logic [ENTRY_BITS-1:0]  idx
  );
    logic [NUM_ENTRIES-2:0] treeOut;
    int                     node;
    treeOut = treeIn;
    node    = 0;
    for (int lvl = 0; lvl < ENTRY_BITS; lvl++) begin
      treeOut[node] = ~idx[ENTRY_BITS-1-lvl];
      node          = 2 * node + 1 + int'(idx[ENTRY_BITS-1-lvl]);
    end
    return treeOut;
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // Victim selection
  ////////////////////////////////////////////////////////////////////////////

  // Follow the tree bits from the root, one address bit per level
  always_comb begin
    int node;
    node       = 0;
    treeVictim = '0;
    for (int lvl = 0; lvl < ENTRY_BITS; lvl++) begin
      treeVictim[ENTRY_BITS-1-lvl] = tree[node];
      node = 2 * node + 1 + int'(tree[node]);
    end
  end

  // Lowest empty slot, found by scanning downward
  always_comb begin
    freeIndex = '0;
    for (int i = NUM_ENTRIES - 1; i >= 0; i--) begin
      if (!validVec[i]) begin
        freeIndex = ENTRY_BITS'(i);
      end
    end
  end

  assign anyFree    = ~&validVec;
  assign writeIndex = anyFree ? freeIndex : treeVictim;

  ////////////////////////////////////////////////////////////////////////////
  // Tree update
  ////////////////////////////////////////////////////////////////////////////

  // A hit and a write on the same edge both count, the write goes last
  always_comb begin
    treeNext = tree;
    if (tlbHit) begin
      treeNext = touchTree(treeNext, hitIndex);
    end
    if (tlbWrite) begin
      treeNext = touchTree(treeNext, writeIndex);
    end
  end

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      tree <= '0;
    end else begin
      tree <= treeNext;
    end
  end

endmodule

// ==== src/tlb.sv ====
/*
  SV32 data TLB for the memory unit. Decodes satp, looks the virtual page
  up in a single cycle, checks the access against the PTE flags and forms
  the 34-bit physical address. New entries arrive from a page-table walker.
*/

`timescale 1ns/1ps

module tlb (
  input  logic                          clk,
  input  logic                          rstN,

  // satp CSR and the status bits that affect permission checks
  input  logic [31:0]                   satp,
  input  logic                          statusMxr,
  input  logic                          statusSum,

  // Current privilege and the kind of access being made
  input  tlbPkg::privMode_t             privilegeMode,
  input  tlbPkg::accessType_t           accessType,

  // Address to translate
  input  logic [tlbPkg::VA_BITS-1:0]    virtualAddress,

  // Entry write from the walker
  input  logic [31:0]                   pteWrite,
  input  tlbPkg::pageType_t             pageTypeWrite,
  input  logic                          tlbWrite,

  // Drop every cached translation
  input  logic                          tlbFlush,

  output logic [tlbPkg::PA_BITS-1:0]    physicalAddress,
  output logic                          tlbHit,
  output logic                          tlbMiss,
  output logic                          pageFault
);

  import tlbPkg::*;

  // Lookup decode
  logic                   translate;
  logic                   readAccess;
  logic                   writeAccess;
  logic                   tlbAccess;
  logic [VPN_BITS-1:0]    vpn;
  logic [OFFSET_BITS-1:0] pageOffset;

  // Results from the tag store, data store and replacement unit
  logic                   camHit;
  logic [ENTRY_BITS-1:0]  hitIndex;
  pageType_t              hitPageType;
  logic [NUM_ENTRIES-1:0] validVec;
  logic [ENTRY_BITS-1:0]  writeIndex;
  logic [PPN_BITS-1:0]    ppn;
  logic [PERM_BITS-1:0]   perm;

  // Flag bits of the entry that hit
  logic pteU;
  logic pteX;
  logic pteW;
  logic pteR;

  // Fault terms
  logic improperPriv;
  logic invalidRead;
  logic invalidWrite;

  // Address assembly
  logic [PPN_BITS-1:0] ppnMixed;
  logic [PA_BITS-1:0]  translatedAddress;

  ////////////////////////////////////////////////////////////////////////////
  // Lookup decode
  ////////////////////////////////////////////////////////////////////////////

  // SV32 has a one-bit mode field at the top of satp
  // Machine mode never translates data accesses here
  assign translate = satp[31] && (privilegeMode != privMachine);

  assign readAccess  = accessType[1];
  assign writeAccess = accessType[0];
  assign tlbAccess   = readAccess || writeAccess;

  assign vpn        = virtualAddress[VA_BITS-1:OFFSET_BITS];
  assign pageOffset = virtualAddress[OFFSET_BITS-1:0];

  ////////////////////////////////////////////////////////////////////////////
  // Storage and replacement
  ////////////////////////////////////////////////////////////////////////////

  tlbCam uCam (
    .clk           (clk),
    .rstN          (rstN),
    .vpn           (vpn),
    .tlbWrite      (tlbWrite),
    .tlbFlush      (tlbFlush),
    .writeIndex    (writeIndex),
    .pageTypeWrite (pageTypeWrite),
    .camHit        (camHit),
    .hitIndex      (hitIndex),
    .hitPageType   (hitPageType),
    .validVec      (validVec)
  );

  tlbRam uRam (
    .clk        (clk),
    .tlbWrite   (tlbWrite),
    .writeIndex (writeIndex),
    .pteWrite   (pteWrite),
    .hitIndex   (hitIndex),
    .ppn        (ppn),
    .perm       (perm)
  );

  // Only real translated hits age the tree
  tlbLru uLru (
    .clk        (clk),
    .rstN       (rstN),
    .tlbHit     (tlbHit),
    .hitIndex   (hitIndex),
    .tlbWrite   (tlbWrite),
    .validVec   (validVec),
    .writeIndex (writeIndex)
  );

  ////////////////////////////////////////////////////////////////////////////
  // Hit and miss
  ////////////////////////////////////////////////////////////////////////////

  assign tlbHit = translate && tlbAccess && camHit;

  // The walker is not started while the table is being flushed
  assign tlbMiss = translate && tlbAccess && !camHit && !tlbFlush;

  ////////////////////////////////////////////////////////////////////////////
  // Permission checks
  ////////////////////////////////////////////////////////////////////////////

  assign pteU = perm[4];
  assign pteX = perm[3];
  assign pteW = perm[2];
  assign pteR = perm[1];

  // User code sees only U pages, supervisor reaches U pages only under SUM
  assign improperPriv = ((privilegeMode == privUser) && !pteU) ||
                        ((privilegeMode == privSuper) && pteU && !statusSum);

  // MXR lets loads read pages that are executable but not readable
  assign invalidRead = readAccess && !pteR && !(statusMxr && pteX);

  assign invalidWrite = writeAccess && !pteW;

  assign pageFault = tlbHit && (improperPriv || invalidRead || invalidWrite);

  ////////////////////////////////////////////////////////////////////////////
  // Physical address
  ////////////////////////////////////////////////////////////////////////////

  // In a megapage VPN0 passes through as part of the page offset
  assign ppnMixed = (hitPageType == pageMega) ?
                    {ppn[PPN_BITS-1:VPN_SEG_BITS], vpn[VPN_SEG_BITS-1:0]} :
                    ppn;

  // A translated miss yields zero so a stale address is never used
  assign translatedAddress = tlbHit ? {ppnMixed, pageOffset} : '0;

  assign physicalAddress = translate ? translatedAddress :
                           {{(PA_BITS - VA_BITS){1'b0}}, virtualAddress};

endmodule

// ==== verif/tlbTb.sv ====
/*
  Directed testbench for the SV32 data TLB. Runs one task per behavior
  (bypass, kilopage, megapage, permission faults, flush, replacement),
  prints a line per test and a closing summary.
*/

`timescale 1ns/1ps

module tlbTb;

  import tlbPkg::*;

  // Longest test is the permission table at about six cycles per row, the
  // whole run stays far below this bound
  localparam int          TIMEOUT_CYCLES = 2000;
  localparam logic [31:0] SATP_ON        = 32'h8000_0000;

  logic                clk;
  logic                rstN;
  logic [31:0]         satp;
  logic                statusMxr;
  logic                statusSum;
  privMode_t           privilegeMode;
  accessType_t         accessType;
  logic [VA_BITS-1:0]  virtualAddress;
  logic [31:0]         pteWrite;
  pageType_t           pageTypeWrite;
  logic                tlbWrite;
  logic                tlbFlush;
  logic [PA_BITS-1:0]  physicalAddress;
  logic                tlbHit;
  logic                tlbMiss;
  logic                pageFault;

  int cycleCount = 0;
  int checkCount = 0;
  int errorCount = 0;
  int testCount  = 0;

  tlb UUT (
    .clk             (clk),
    .rstN            (rstN),
    .satp            (satp),
    .statusMxr       (statusMxr),
    .statusSum       (statusSum),
    .privilegeMode   (privilegeMode),
    .accessType      (accessType),
    .virtualAddress  (virtualAddress),
    .pteWrite        (pteWrite),
    .pageTypeWrite   (pageTypeWrite),
    .tlbWrite        (tlbWrite),
    .tlbFlush        (tlbFlush),
    .physicalAddress (physicalAddress),
    .tlbHit          (tlbHit),
    .tlbMiss         (tlbMiss),
    .pageFault       (pageFault)
  );

  // 40 ns clock period
  always #20 clk = ~clk;

  always @(posedge clk) begin
    cycleCount++;
    if (cycleCount >= TIMEOUT_CYCLES) begin
      $display("Timeout after %0d cycles, a test never finished", cycleCount);
      $display("*** FAILED ***");
      $finish;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////////////////////////////////////////

  // Inputs change 2 ns after the rising edge
  task automatic nextCycle();
    @(posedge clk);
    #2;
  endtask

  task automatic compareValue(input string name, input logic [63:0] got,
                              input logic [63:0] expected);
    checkCount++;
    if (got !== expected) begin
      errorCount++;
      $display("[ERROR] %s: got 0x%0h, expected 0x%0h", name, got, expected);
    end
  endtask

  task automatic reportTest(input string name, input int errorsAtStart);
    testCount++;
    if (errorCount == errorsAtStart) begin
      $display("%s: ok", name);
    end else begin
      $display("%s: %0d errors", name, errorCount - errorsAtStart);
    end
  endtask

  // PTE with A and D set, V set and the U X W R flags given
  function automatic logic [31:0] makePte(input logic [PPN_BITS-1:0] ppnVal,
                                          input logic [3:0] uxwr);
    return {ppnVal, 2'b00, 2'b11, 1'b0, uxwr, 1'b1};
  endfunction

  task automatic setMode(input logic [31:0] satpVal, input privMode_t priv,
                         input logic sum, input logic mxr);
    nextCycle();
    satp          = satpVal;
    privilegeMode = priv;
    statusSum     = sum;
    statusMxr     = mxr;
  endtask

  task automatic flushTable();
    nextCycle();
    accessType = accNone;
    tlbFlush   = 1'b1;
    nextCycle();
    tlbFlush   = 1'b0;
  endtask

  // The lookup address carries the VPN that the tag store captures
  task automatic writeEntry(input logic [VPN_BITS-1:0] vpn, input logic [31:0] pte,
                            input pageType_t pageType);
    nextCycle();
    accessType     = accNone;
    virtualAddress = {vpn, 12'h000};
    pteWrite       = pte;
    pageTypeWrite  = pageType;
    tlbWrite       = 1'b1;
    nextCycle();
    tlbWrite       = 1'b0;
  endtask

  // Outputs are combinational, sampled 10 ns after the inputs change
  task automatic lookup(input logic [VA_BITS-1:0] va, input accessType_t acc);
    nextCycle();
    virtualAddress = va;
    accessType     = acc;
    #10;
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Tests
  ////////////////////////////////////////////////////////////////////////////

  task automatic runBypass();
    int          errorsAtStart;
    logic [31:0] va;
    errorsAtStart = errorCount;
    va = $urandom();
    setMode(32'h0, privSuper, 1'b0, 1'b0);
    // The page is cached without any access rights, so a translation would
    // show up as a hit with a fault and a different address
    writeEntry(va[31:12], makePte(22'h2aaaa, 4'b0000), pageKilo);
    lookup(va, accRead);
    compareValue("physicalAddress", physicalAddress, {2'b00, va});
    compareValue("tlbHit", tlbHit, 1'b0);
    compareValue("tlbMiss", tlbMiss, 1'b0);
    compareValue("pageFault", pageFault, 1'b0);
    // Machine mode ignores satp
    setMode(SATP_ON, privMachine, 1'b0, 1'b0);
    lookup(va, accReadWrite);
    compareValue("physicalAddress", physicalAddress, {2'b00, va});
    compareValue("tlbHit", tlbHit, 1'b0);
    compareValue("tlbMiss", tlbMiss, 1'b0);
    compareValue("pageFault", pageFault, 1'b0);
    reportTest("bypass", errorsAtStart);
  endtask

  task automatic runKilopage();
    int                     errorsAtStart;
    logic [31:0]            rnd;
    logic [VPN_BITS-1:0]    vpn;
    logic [PPN_BITS-1:0]    ppn;
    logic [OFFSET_BITS-1:0] offset;
    errorsAtStart = errorCount;
    rnd    = $urandom();
    vpn    = rnd[19:0];
    offset = rnd[31:20];
    rnd    = $urandom();
    ppn    = rnd[21:0];
    setMode(SATP_ON, privSuper, 1'b0, 1'b0);
    flushTable();
    writeEntry(vpn, makePte(ppn, 4'b0011), pageKilo);
    lookup({vpn, offset}, accRead);
    compareValue("tlbHit", tlbHit, 1'b1);
    compareValue("tlbMiss", tlbMiss, 1'b0);
    compareValue("pageFault", pageFault, 1'b0);
    compareValue("physicalAddress", physicalAddress, {ppn, offset});
    // Neighbouring page was never written
    lookup({vpn + 20'd1, offset}, accRead);
    compareValue("tlbHit", tlbHit, 1'b0);
    compareValue("tlbMiss", tlbMiss, 1'b1);
    compareValue("physicalAddress", physicalAddress, 34'h0);
    reportTest("kilopage", errorsAtStart);
  endtask

  task automatic runMegapage();
    int                     errorsAtStart;
    logic [31:0]            rnd;
    logic [VPN_BITS-1:0]    vpn;
    logic [PPN_BITS-1:0]    ppn;
    logic [OFFSET_BITS-1:0] offset;
    logic [VPN_SEG_BITS-1:0] vpnZeroB;
    errorsAtStart = errorCount;
    rnd      = $urandom();
    vpn      = rnd[19:0];
    offset   = rnd[31:20];
    rnd      = $urandom();
    ppn      = rnd[21:0];
    vpnZeroB = ~vpn[9:0];
    setMode(SATP_ON, privSuper, 1'b0, 1'b0);
    flushTable();
    writeEntry(vpn, makePte(ppn, 4'b0011), pageMega);
    // Two addresses inside the same 4 MiB region
    lookup({vpn, offset}, accRead);
    compareValue("tlbHit", tlbHit, 1'b1);
    compareValue("physicalAddress", physicalAddress, {ppn[21:10], vpn[9:0], offset});
    lookup({vpn[19:10], vpnZeroB, offset}, accRead);
    compareValue("tlbHit", tlbHit, 1'b1);
    compareValue("physicalAddress", physicalAddress, {ppn[21:10], vpnZeroB, offset});
    reportTest("megapage", errorsAtStart);
  endtask

  // One row of the permission table, flags given as U X W R
  task automatic checkPermission(input privMode_t priv, input logic sum, input logic mxr,
                                 input accessType_t acc, input logic [3:0] uxwr,
                                 input logic expectFault);
    setMode(SATP_ON, priv, sum, mxr);
    flushTable();
    writeEntry(20'h12345, makePte(22'h2abcd, uxwr), pageKilo);
    lookup(32'h1234_5678, acc);
    compareValue("tlbHit", tlbHit, 1'b1);
    compareValue("pageFault", pageFault, expectFault);
  endtask

  task automatic runPermissions();
    int errorsAtStart;
    errorsAtStart = errorCount;
    checkPermission(privUser,  1'b0, 1'b0, accRead,      4'b1001, 1'b0);
    checkPermission(privUser,  1'b0, 1'b0, accRead,      4'b0001, 1'b1);
    checkPermission(privSuper, 1'b0, 1'b0, accRead,      4'b1001, 1'b1);
    checkPermission(privSuper, 1'b1, 1'b0, accRead,      4'b1001, 1'b0);
    // Execute-only page, readable only through MXR
    checkPermission(privSuper, 1'b0, 1'b0, accRead,      4'b0100, 1'b1);
    checkPermission(privSuper, 1'b0, 1'b1, accRead,      4'b0100, 1'b0);
    checkPermission(privSuper, 1'b0, 1'b1, accRead,      4'b0010, 1'b1);
    checkPermission(privSuper, 1'b0, 1'b0, accWrite,     4'b0001, 1'b1);
    checkPermission(privSuper, 1'b0, 1'b0, accWrite,     4'b0011, 1'b0);
    checkPermission(privSuper, 1'b0, 1'b0, accReadWrite, 4'b0001, 1'b1);
    checkPermission(privUser,  1'b0, 1'b0, accReadWrite, 4'b1011, 1'b0);
    reportTest("permissions", errorsAtStart);
  endtask

  task automatic runFlush();
    int errorsAtStart;
    errorsAtStart = errorCount;
    setMode(SATP_ON, privSuper, 1'b0, 1'b0);
    flushTable();
    writeEntry(20'h0beef, makePte(22'h00123, 4'b0011), pageKilo);
    lookup(32'h0bee_f010, accRead);
    compareValue("tlbHit", tlbHit, 1'b1);
    // An unmapped page during the flush cycle would miss otherwise
    nextCycle();
    tlbFlush       = 1'b1;
    virtualAddress = 32'h0cafe_000;
    accessType     = accRead;
    #10;
    compareValue("tlbMiss", tlbMiss, 1'b0);
    nextCycle();
    tlbFlush = 1'b0;
    lookup(32'h0bee_f010, accRead);
    compareValue("tlbHit", tlbHit, 1'b0);
    compareValue("tlbMiss", tlbMiss, 1'b1);
    reportTest("flush", errorsAtStart);
  endtask

  task automatic runReplacement();
    int                  errorsAtStart;
    int                  missCount;
    logic [31:0]         rnd;
    logic [VPN_BITS-1:0] vpnList [9];
    logic [PPN_BITS-1:0] ppnList [9];
    errorsAtStart = errorCount;
    missCount     = 0;
    rnd           = $urandom();
    for (int i = 0; i < 9; i++) begin
      vpnList[i] = rnd[19:0] + 20'(i);
      ppnList[i] = 22'($urandom());
    end
    setMode(SATP_ON, privSuper, 1'b0, 1'b0);
    flushTable();
    for (int i = 0; i < 8; i++) begin
      writeEntry(vpnList[i], makePte(ppnList[i], 4'b0011), pageKilo);
    end
    for (int i = 0; i < 8; i++) begin
      lookup({vpnList[i], 12'h0a4}, accRead);
      compareValue("tlbHit", tlbHit, 1'b1);
      compareValue("physicalAddress", physicalAddress, {ppnList[i], 12'h0a4});
    end
    // Table is full, so the ninth page evicts exactly one entry
    writeEntry(vpnList[8], makePte(ppnList[8], 4'b0011), pageKilo);
    lookup({vpnList[8], 12'h0a4}, accRead);
    compareValue("tlbHit", tlbHit, 1'b1);
    compareValue("physicalAddress", physicalAddress, {ppnList[8], 12'h0a4});
    for (int i = 0; i < 8; i++) begin
      lookup({vpnList[i], 12'h0a4}, accRead);
      if (tlbMiss) begin
        missCount++;
      end
    end
    checkCount++;
    if (missCount != 1) begin
      errorCount++;
      $display("Replacement: %0d of the first eight pages miss instead of one", missCount);
    end
    reportTest("replacement", errorsAtStart);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    clk            = 1'b0;
    rstN           = 1'b0;
    satp           = 32'h0;
    statusMxr      = 1'b0;
    statusSum      = 1'b0;
    privilegeMode  = privSuper;
    accessType     = accNone;
    virtualAddress = '0;
    pteWrite       = 32'h0;
    pageTypeWrite  = pageKilo;
    tlbWrite       = 1'b0;
    tlbFlush       = 1'b0;
    void'($urandom(32'h94f1449e));
    repeat (3) @(posedge clk);
    #2;
    rstN = 1'b1;
    runBypass();
    runKilopage();
    runMegapage();
    runPermissions();
    runFlush();
    runReplacement();
    $display("Summary: %0d tests, %0d checks, %0d errors", testCount, checkCount,
             errorCount);
    if (errorCount == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule

// ==== all.f ====
src/tlbPkg.sv
src/tlbCam.sv
src/tlbRam.sv
src/tlbLru.sv
src/tlb.sv
verif/tlbTb.sv

// ==== Makefile ====
# Verilator build and run of the data TLB testbench

LOG := sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove build output and the log"
	@echo "  help   show this list"

test:
	verilator --binary --timing -Wno-fatal -f all.f --top-module tlbTb -o tlbSim
	./obj_dir/tlbSim | tee $(LOG)
	grep -q '\*\*\* PASSED \*\*\*' $(LOG)

clean:
	rm -rf obj_dir $(LOG)
